// File: soc_pkg.sv
package soc_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 64;
  localparam int unsigned BE_W     = DATA_W / 8;
  // Byte offset bits inside one bus word
  localparam int unsigned WORD_OFS = $clog2(BE_W);
  localparam int unsigned WORD_AW  = ADDR_W - WORD_OFS;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [ADDR_W-1:0]   ROM_BASE   = 32'h0001_0000;
  localparam int unsigned         ROM_WORDS  = 64;
  localparam int unsigned         ROM_AW     = $clog2(ROM_WORDS);
  localparam logic [DATA_W/2-1:0] ROM_TAG    = 32'hB007_C0DE;

  localparam logic [ADDR_W-1:0]   SRAM_BASE  = 32'h8000_0000;
  localparam int unsigned         SRAM_WORDS = 256;
  localparam int unsigned         SRAM_AW    = $clog2(SRAM_WORDS);

  // Debug request hold-off after reset
  localparam int unsigned DEBUG_HOLD_CYCLES = 20;
  localparam int unsigned HOLD_CNT_W        = $clog2(DEBUG_HOLD_CYCLES + 1);

  // ----------------------------------------
  // Bus types
  // ----------------------------------------
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic {
    MST_HOST,
    MST_DEBUG
  } master_e;

  typedef enum logic [1:0] {
    SEL_ROM,
    SEL_SRAM,
    SEL_ERR
  } slave_sel_e;

endpackage

// File: bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::bus_req_t host_req_i,
  input  soc_pkg::bus_req_t dbg_req_i,
  output logic              host_gnt_o,
  output logic              dbg_gnt_o,
  output soc_pkg::bus_rsp_t host_rsp_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  output soc_pkg::bus_req_t bus_req_o,
  input  soc_pkg::bus_rsp_t bus_rsp_i
);

  // Round-robin state, the last master that won a grant
  soc_pkg::master_e last_q;
  // Master that owns the response of the next cycle
  soc_pkg::master_e owner_q;

  // Contested cycles go to the master not granted most recently
  assign host_gnt_o = host_req_i.req &&
                      (!dbg_req_i.req || last_q == soc_pkg::MST_DEBUG);
  assign dbg_gnt_o  = dbg_req_i.req &&
                      (!host_req_i.req || last_q == soc_pkg::MST_HOST);

  always_comb begin
    bus_req_o     = dbg_gnt_o ? dbg_req_i : host_req_i;
    bus_req_o.req = host_gnt_o || dbg_gnt_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Host wins the first contest
      last_q  <= soc_pkg::MST_DEBUG;
      owner_q <= soc_pkg::MST_HOST;
    end else begin
      if (host_gnt_o) begin
        last_q <= soc_pkg::MST_HOST;
      end else if (dbg_gnt_o) begin
        last_q <= soc_pkg::MST_DEBUG;
      end
      owner_q <= dbg_gnt_o ? soc_pkg::MST_DEBUG : soc_pkg::MST_HOST;
    end
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  assign host_rsp_o = (owner_q == soc_pkg::MST_HOST)  ? bus_rsp_i : '0;
  assign dbg_rsp_o  = (owner_q == soc_pkg::MST_DEBUG) ? bus_rsp_i : '0;

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(host_gnt_o && dbg_gnt_o)
  );

endmodule

// File: slave_router.sv
`timescale 1ns/1ns

module slave_router (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  soc_pkg::bus_req_t                   bus_req_i,
  output soc_pkg::bus_rsp_t                   bus_rsp_o,
  output logic                                rom_cs_o,
  output logic [soc_pkg::ROM_AW-1:0]          rom_addr_o,
  input  logic [soc_pkg::DATA_W-1:0]          rom_rdata_i,
  output logic                                sram_cs_o,
  output logic                                sram_we_o,
  output logic [soc_pkg::WORD_AW-1:0]         sram_addr_o,
  output logic [soc_pkg::BE_W-1:0]            sram_be_o,
  output logic [soc_pkg::DATA_W-1:0]          sram_wdata_o,
  input  logic [soc_pkg::DATA_W-1:0]          sram_rdata_i
);

  logic [soc_pkg::ADDR_W-1:0] rom_off;
  logic [soc_pkg::ADDR_W-1:0] sram_off;
  soc_pkg::slave_sel_e        sel;
  soc_pkg::slave_sel_e        rsp_sel;
  soc_pkg::slave_sel_e        sel_q;
  logic                       req_err;
  logic                       err_q;
  logic                       valid_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  // Offsets wrap below the base, so one compare covers the range
  assign rom_off  = bus_req_i.addr - soc_pkg::ROM_BASE;
  assign sram_off = bus_req_i.addr - soc_pkg::SRAM_BASE;

  always_comb begin
    if (rom_off < soc_pkg::ROM_WORDS * soc_pkg::BE_W) begin
      sel = soc_pkg::SEL_ROM;
    end else if (sram_off < soc_pkg::SRAM_WORDS * soc_pkg::BE_W) begin
      sel = soc_pkg::SEL_SRAM;
    end else begin
      sel = soc_pkg::SEL_ERR;
    end
  end

  assign req_err = (sel == soc_pkg::SEL_ERR) || (sel == soc_pkg::SEL_ROM && bus_req_i.we);
  // Writes and errors answer with zero data
  assign rsp_sel = (bus_req_i.we || req_err) ? soc_pkg::SEL_ERR : sel;

  assign rom_cs_o     = bus_req_i.req && sel == soc_pkg::SEL_ROM && !bus_req_i.we;
  assign rom_addr_o   = rom_off[soc_pkg::ROM_AW+soc_pkg::WORD_OFS-1:soc_pkg::WORD_OFS];
  assign sram_cs_o    = bus_req_i.req && sel == soc_pkg::SEL_SRAM;
  assign sram_we_o    = bus_req_i.we;
  assign sram_addr_o  = sram_off[soc_pkg::ADDR_W-1:soc_pkg::WORD_OFS];
  assign sram_be_o    = bus_req_i.be;
  assign sram_wdata_o = bus_req_i.wdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      sel_q   <= soc_pkg::SEL_ERR;
    end else begin
      valid_q <= bus_req_i.req;
      err_q   <= bus_req_i.req && req_err;
      sel_q   <= bus_req_i.req ? rsp_sel : soc_pkg::SEL_ERR;
    end
  end

  // Response mux
  always_comb begin
    bus_rsp_o.rvalid = valid_q;
    bus_rsp_o.err    = err_q;
    case (sel_q)
      soc_pkg::SEL_ROM:  bus_rsp_o.rdata = rom_rdata_i;
      soc_pkg::SEL_SRAM: bus_rsp_o.rdata = sram_rdata_i;
      default:           bus_rsp_o.rdata = '0;
    endcase
  end

  // Each response follows a request taken by a memory or the error path
  a_rvalid_after_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_o.rvalid |-> $past(rom_cs_o || sram_cs_o || (bus_req_i.req && req_err))
  );

endmodule

// File: boot_rom.sv
`timescale 1ns/1ns

module boot_rom (
  input  logic                       clk_i,
  input  logic                       cs_i,
  input  logic [soc_pkg::ROM_AW-1:0] addr_i,
  output logic [soc_pkg::DATA_W-1:0] rdata_o
);

  logic [soc_pkg::DATA_W-1:0] rom_word;

  // Tag in the upper half, word index in the lower half
  assign rom_word = {
    soc_pkg::ROM_TAG,
    {(soc_pkg::DATA_W / 2 - soc_pkg::ROM_AW){1'b0}},
    addr_i
  };

  // One cycle read latency
  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule

// File: data_sram.sv
`timescale 1ns/1ns

module data_sram (
  input  logic                        clk_i,
  input  logic                        cs_i,
  input  logic                        we_i,
  input  logic [soc_pkg::WORD_AW-1:0] addr_i,
  input  logic [soc_pkg::BE_W-1:0]    be_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o
);

  logic [soc_pkg::DATA_W-1:0]  mem_q [soc_pkg::SRAM_WORDS];
  logic [soc_pkg::SRAM_AW-1:0] idx;

  assign idx = addr_i[soc_pkg::SRAM_AW-1:0];

  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      if (we_i) begin
        // Byte lanes under their enables
        for (int b = 0; b < soc_pkg::BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  // Router decode must keep the index inside the array
  a_addr_in_range : assert property (
    @(posedge clk_i)
    cs_i |-> addr_i < soc_pkg::SRAM_WORDS
  );

endmodule

// File: debug_req_gate.sv
`timescale 1ns/1ns

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_en_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [soc_pkg::HOLD_CNT_W-1:0] hold_q;
  logic                           hold_done;

  // Counts down once per cycle and stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= soc_pkg::HOLD_CNT_W'(soc_pkg::DEBUG_HOLD_CYCLES);
    end else if (!hold_done) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  assign hold_done = (hold_q == '0);

  // Blocked during hold-off and while debug is disabled
  assign debug_req_o = hold_done && debug_en_i && debug_req_i;

endmodule

// File: soc_fabric.sv
`timescale 1ns/1ns

module soc_fabric (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::bus_req_t host_req_i,
  output logic              host_gnt_o,
  output soc_pkg::bus_rsp_t host_rsp_o,
  input  soc_pkg::bus_req_t dbg_req_i,
  output logic              dbg_gnt_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  input  logic              debug_en_i,
  input  logic              debug_req_i,
  output logic              debug_req_o
);

  soc_pkg::bus_req_t bus_req;
  soc_pkg::bus_rsp_t bus_rsp;

  logic                        rom_cs;
  logic [soc_pkg::ROM_AW-1:0]  rom_addr;
  logic [soc_pkg::DATA_W-1:0]  rom_rdata;

  logic                        sram_cs;
  logic                        sram_we;
  logic [soc_pkg::WORD_AW-1:0] sram_addr;
  logic [soc_pkg::BE_W-1:0]    sram_be;
  logic [soc_pkg::DATA_W-1:0]  sram_wdata;
  logic [soc_pkg::DATA_W-1:0]  sram_rdata;

  // ----------------------------------------
  // Shared bus
  // ----------------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .host_req_i ( host_req_i ),
    .dbg_req_i  ( dbg_req_i  ),
    .host_gnt_o ( host_gnt_o ),
    .dbg_gnt_o  ( dbg_gnt_o  ),
    .host_rsp_o ( host_rsp_o ),
    .dbg_rsp_o  ( dbg_rsp_o  ),
    .bus_req_o  ( bus_req    ),
    .bus_rsp_i  ( bus_rsp    )
  );

  slave_router i_slave_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bus_req_i    ( bus_req    ),
    .bus_rsp_o    ( bus_rsp    ),
    .rom_cs_o     ( rom_cs     ),
    .rom_addr_o   ( rom_addr   ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_cs_o    ( sram_cs    ),
    .sram_we_o    ( sram_we    ),
    .sram_addr_o  ( sram_addr  ),
    .sram_be_o    ( sram_be    ),
    .sram_wdata_o ( sram_wdata ),
    .sram_rdata_i ( sram_rdata )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .cs_i    ( rom_cs    ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  data_sram i_data_sram (
    .clk_i   ( clk_i      ),
    .cs_i    ( sram_cs    ),
    .we_i    ( sram_we    ),
    .addr_i  ( sram_addr  ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  // Core debug request hold-off
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: tb_soc_fabric.sv
`timescale 1ns/1ns

module tb_soc_fabric;

  localparam int unsigned NUM_OPS        = 400;
  localparam int unsigned TIMEOUT_CYCLES = 4 * NUM_OPS + soc_pkg::DEBUG_HOLD_CYCLES + 50;

  logic              clk_i;
  logic              rst_ni;
  soc_pkg::bus_req_t host_req;
  logic              host_gnt;
  soc_pkg::bus_rsp_t host_rsp;
  soc_pkg::bus_req_t dbg_req;
  logic              dbg_gnt;
  soc_pkg::bus_rsp_t dbg_rsp;
  logic              debug_en;
  logic              debug_req;
  logic              debug_req_out;

  // Reference model state
  logic [31:0]                lfsr_q;
  logic [soc_pkg::DATA_W-1:0] sram_model [soc_pkg::SRAM_WORDS];
  bit                         written [soc_pkg::SRAM_WORDS];
  int unsigned                written_q [$];
  soc_pkg::bus_rsp_t          host_exp_q [$];
  soc_pkg::bus_rsp_t          dbg_exp_q [$];
  soc_pkg::master_e           last_mst;
  logic                       host_taken;
  logic                       dbg_taken;
  int unsigned                ops_done;
  int unsigned                cycle_cnt;
  int unsigned                contest_cnt;
  int unsigned                debug_on_cnt;

  soc_fabric UUT (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .host_req_i  ( host_req      ),
    .host_gnt_o  ( host_gnt      ),
    .host_rsp_o  ( host_rsp      ),
    .dbg_req_i   ( dbg_req       ),
    .dbg_gnt_o   ( dbg_gnt       ),
    .dbg_rsp_o   ( dbg_rsp       ),
    .debug_en_i  ( debug_en      ),
    .debug_req_i ( debug_req     ),
    .debug_req_o ( debug_req_out )
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: %0d operations did not finish in %0d cycles", NUM_OPS, cycle_cnt);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // ----------------------------------------
  // Random numbers
  // ----------------------------------------
  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic make_req(output soc_pkg::bus_req_t r);
    logic [1:0]  kind;
    logic [26:0] ofs;
    int unsigned idx;
    r     = '0;
    r.req = 1'b1;
    kind  = rand_bits(2);
    r.we  = rand_bits(1);
    case (kind)
      2'd0: r.addr = soc_pkg::ROM_BASE + rand_bits(soc_pkg::ROM_AW) * soc_pkg::BE_W;
      2'd3: begin
        // Somewhere in 0x4000_0000 .. 0x7fff_fff8, nothing mapped there
        ofs    = rand_bits(27);
        r.addr = {2'b01, ofs, 3'b000};
      end
      default: begin
        if (written_q.size() == 0) begin
          r.we = 1'b1;
        end
        if (r.we) begin
          idx = rand_bits(soc_pkg::SRAM_AW);
        end else begin
          idx = written_q[rand_bits(16) % written_q.size()];
        end
        r.addr = soc_pkg::SRAM_BASE + idx * soc_pkg::BE_W;
      end
    endcase
    r.be    = rand_bits(soc_pkg::BE_W);
    r.wdata = rand_bits(soc_pkg::DATA_W);
  endtask

  // Expected response of one accepted request, memory model updated
  task automatic model_access(input soc_pkg::bus_req_t r, output soc_pkg::bus_rsp_t rsp);
    int unsigned idx;
    rsp        = '0;
    rsp.rvalid = 1'b1;
    if (r.addr >= soc_pkg::ROM_BASE &&
        r.addr < soc_pkg::ROM_BASE + soc_pkg::ROM_WORDS * soc_pkg::BE_W) begin
      idx = (r.addr - soc_pkg::ROM_BASE) / soc_pkg::BE_W;
      if (r.we) begin
        rsp.err = 1'b1;
      end else begin
        rsp.rdata = {soc_pkg::ROM_TAG, idx};
      end
    end else if (r.addr >= soc_pkg::SRAM_BASE &&
                 r.addr < soc_pkg::SRAM_BASE + soc_pkg::SRAM_WORDS * soc_pkg::BE_W) begin
      idx = (r.addr - soc_pkg::SRAM_BASE) / soc_pkg::BE_W;
      if (r.we) begin
        for (int b = 0; b < soc_pkg::BE_W; b++) begin
          if (r.be[b]) begin
            sram_model[idx][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
        if (!written[idx]) begin
          written[idx] = 1'b1;
          written_q.push_back(idx);
        end
      end else begin
        rsp.rdata = sram_model[idx];
      end
    end else begin
      rsp.err = 1'b1;
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_rsp(input string name, input soc_pkg::bus_rsp_t exp,
                           input soc_pkg::bus_rsp_t act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_gnt(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_debug(input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR debug_req_o expected 0x%h actual 0x%h", exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // One sample point, between the falling and the next rising edge
  task automatic check_cycle(input int unsigned cyc);
    soc_pkg::bus_rsp_t exp_rsp;
    logic              exp_host;
    logic              exp_dbg;
    exp_rsp = '0;
    if (host_exp_q.size() != 0) begin
      exp_rsp = host_exp_q.pop_front();
    end
    check_rsp("host_rsp_o", exp_rsp, host_rsp);
    exp_rsp = '0;
    if (dbg_exp_q.size() != 0) begin
      exp_rsp = dbg_exp_q.pop_front();
    end
    check_rsp("dbg_rsp_o", exp_rsp, dbg_rsp);

    // Contested cycles go to whoever lost the last grant
    if (host_req.req && dbg_req.req) begin
      exp_host = (last_mst != soc_pkg::MST_HOST);
      exp_dbg  = !exp_host;
      contest_cnt++;
    end else begin
      exp_host = host_req.req;
      exp_dbg  = dbg_req.req;
    end
    if (host_gnt === 1'b1 && dbg_gnt === 1'b1) begin
      $display("Both masters were granted in the same cycle");
      $display("TEST FAILED");
      $fatal(1);
    end
    check_gnt("host_gnt_o", exp_host, host_gnt);
    check_gnt("dbg_gnt_o", exp_dbg, dbg_gnt);

    host_taken = exp_host;
    dbg_taken  = exp_dbg;
    if (exp_host) begin
      model_access(host_req, exp_rsp);
      host_exp_q.push_back(exp_rsp);
      last_mst = soc_pkg::MST_HOST;
      ops_done++;
    end
    if (exp_dbg) begin
      model_access(dbg_req, exp_rsp);
      dbg_exp_q.push_back(exp_rsp);
      last_mst = soc_pkg::MST_DEBUG;
      ops_done++;
    end

    check_debug((cyc >= soc_pkg::DEBUG_HOLD_CYCLES) && debug_en && debug_req, debug_req_out);
    if (debug_req_out === 1'b1) begin
      debug_on_cnt++;
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int unsigned cyc;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    host_req     = '0;
    dbg_req      = '0;
    debug_en     = 1'b0;
    debug_req    = 1'b0;
    lfsr_q       = 32'd98169;
    last_mst     = soc_pkg::MST_DEBUG;
    host_taken   = 1'b0;
    dbg_taken    = 1'b0;
    ops_done     = 0;
    cycle_cnt    = 0;
    contest_cnt  = 0;
    debug_on_cnt = 0;
    cyc          = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    while (ops_done < NUM_OPS) begin
      if (host_taken) begin
        host_req = '0;
      end
      if (dbg_taken) begin
        dbg_req = '0;
      end
      // Idle masters start a new request most of the time
      if (!host_req.req && rand_bits(2) != 0) begin
        make_req(host_req);
      end
      if (!dbg_req.req && rand_bits(2) != 0) begin
        make_req(dbg_req);
      end
      debug_en  = (rand_bits(2) != 0);
      debug_req = rand_bits(1);
      #25;
      check_cycle(cyc);
      cyc++;
      @(negedge clk_i);
    end

    // Drain the last responses
    host_req = '0;
    dbg_req  = '0;
    #25;
    check_cycle(cyc);

    if (contest_cnt == 0 || debug_on_cnt == 0) begin
      $display("The run never saw a contested cycle or an active debug request");
      $display("TEST FAILED");
      $fatal(1);
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: verilog.f
soc_pkg.sv
bus_arbiter.sv
slave_router.sv
boot_rom.sv
data_sram.sv
debug_req_gate.sv
soc_fabric.sv
tb_soc_fabric.sv
